/* tb.f */
verilog/uart_io_pkg.sv
verilog/uart_tx.sv
verilog/button_sync.sv
verilog/uart_io_port.sv
verilog/uart_io_top.sv
tb/uart_io_asserts.sv
tb/tb_uart_io.sv

/* Makefile */
# Verilator build and run for the uart io port testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_uart_io -Mdir obj_dir -f tb.f
	./obj_dir/Vtb_uart_io > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "all tests passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* tb/tb_uart_io.sv */
// testbench for the memory mapped uart port
// drives random writes and reads on the bus, decodes the serial line in
// parallel and compares every byte and read value with a reference model

`timescale 1ns/1ps

module tb_uart_io;
	import uart_io_pkg::*;

	localparam int c_ready_timeout = 200;
	localparam int c_drain_timeout = 400;
	localparam int c_decode_cycles = 30;

	logic                      clk;
	logic                      reset_n;
	bus_req_t                  bus_req;
	bus_rsp_t                  bus_rsp;
	logic [c_button_width-1:0] button;
	logic                      uart_tx;

	integer                    seed;
	logic [7:0]                expected_bytes [$];
	logic [c_button_width-1:0] model_buttons;
	int                        write_count;
	int                        decode_count;

	// serial decoder state
	logic       dec_active;
	logic       line_prev;
	int         dec_cnt;
	int         dec_bit;
	logic [7:0] dec_byte;

	uart_io_top i_uart_io_top (
		.clk     (clk),
		.reset_n (reset_n),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp),
		.button  (button),
		.uart_tx (uart_tx)
	);

	always #50 clk = ~clk;

	// ------------------------------------------------------------------
	// checking helpers
	// ------------------------------------------------------------------
	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, msg, actual,
				expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic stop_on_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("tests failed");
		$fatal(1);
	endtask

	// ------------------------------------------------------------------
	// bus driver
	// ------------------------------------------------------------------
	// every task starts and ends 1 ns after a rising edge
	task automatic next_cycle(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// returns at the falling edge before the accepting rising edge
	task automatic wait_ready(input string what);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!bus_rsp.ready) begin
			waited++;
			if (waited > c_ready_timeout) begin
				stop_on_error({"timeout waiting for ready on a ", what});
			end
			@(negedge clk);
		end
	endtask

	task automatic write_port(input logic [7:0] data, input logic hold_valid);
		bus_req.address = c_io_port;
		bus_req.ioreq = 1'b1;
		bus_req.write = 1'b1;
		bus_req.valid = 1'b1;
		bus_req.wdata = data;
		wait_ready("write");
		@(posedge clk);
		expected_bytes.push_back(data);
		write_count++;
		#1;
		if (!hold_valid) begin
			bus_req.valid = 1'b0;
		end
		// the send request is pending now, so the port must not be ready
		@(negedge clk);
		check(32'(bus_rsp.ready), 32'd0, "ready in the cycle after a write");
		next_cycle(1);
		if (!hold_valid) begin
			bus_req.ioreq = 1'b0;
		end
	endtask

	task automatic read_port(input logic [7:0] expected);
		bus_req.address = c_io_port;
		bus_req.ioreq = 1'b1;
		bus_req.write = 1'b0;
		bus_req.valid = 1'b1;
		bus_req.wdata = 8'd0;
		wait_ready("read");
		@(posedge clk);
		#1;
		bus_req.valid = 1'b0;
		@(negedge clk);
		check(32'(bus_rsp.rdata_en), 32'd1, "rdata_en in the cycle after a read");
		check(32'(bus_rsp.rdata), 32'(expected), "read data");
		check(32'(bus_rsp.ready), 32'd0, "ready during the read response");
		@(negedge clk);
		check(32'(bus_rsp.rdata_en), 32'd0, "rdata_en one cycle late");
		check(32'(bus_rsp.rdata), 32'd0, "rdata outside the response cycle");
		next_cycle(1);
		bus_req.ioreq = 1'b0;
	endtask

	task automatic wait_frames_done();
		int waited;
		waited = 0;
		while (expected_bytes.size() != 0 || dec_active) begin
			waited++;
			if (waited > c_drain_timeout) begin
				stop_on_error("timeout waiting for the pending serial frames");
			end
			next_cycle(1);
		end
	endtask

	// ------------------------------------------------------------------
	// serial decoder
	// ------------------------------------------------------------------
	// the first low sample is half a cycle into the start bit, so a bit k
	// is sampled about halfway through at k*c_bit_clocks + c_bit_clocks/2
	always @(negedge clk) begin
		if (!reset_n) begin
			dec_active = 1'b0;
			line_prev = 1'b1;
		end else begin
			if (!dec_active) begin
				if (line_prev && !uart_tx) begin
					dec_active = 1'b1;
					dec_cnt = 0;
					dec_bit = 0;
				end
			end else begin
				dec_cnt++;
				check(32'(bus_rsp.ready), 32'd0, "ready high during a serial frame");
				if (dec_cnt == dec_bit * c_bit_clocks + c_bit_clocks / 2) begin
					if (dec_bit == 0) begin
						check(32'(uart_tx), 32'd0, "start bit level");
					end else if (dec_bit <= 8) begin
						dec_byte[dec_bit-1] = uart_tx;
					end else begin
						check(32'(uart_tx), 32'd1, "stop bit level");
						dec_active = 1'b0;
						if (expected_bytes.size() == 0) begin
							stop_on_error("serial frame seen with no byte written");
						end else begin
							check(32'(dec_byte), 32'(expected_bytes[0]), "serial byte");
							void'(expected_bytes.pop_front());
							decode_count++;
						end
					end
					dec_bit++;
				end
			end
			line_prev = uart_tx;
		end
	end

	// ------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------
	initial begin
		int         pause;
		logic [7:0] data;
		logic [7:0] addr;
		seed = 78;
		clk = 1'b0;
		reset_n = 1'b0;
		bus_req = '0;
		button = '0;
		model_buttons = '0;
		write_count = 0;
		decode_count = 0;
		repeat (4) @(posedge clk);
		#1;
		reset_n = 1'b1;

		// quiet bus after reset
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			check(32'(uart_tx), 32'd1, "line level after reset");
			check(32'(bus_rsp.rdata_en), 32'd0, "rdata_en after reset");
		end
		next_cycle(1);

		// single writes with random gaps
		for (int i = 0; i < 40; i++) begin
			data = 8'($random(seed));
			write_port(data, 1'b0);
			pause = 1 + ($random(seed) & 3);
			next_cycle(pause);
		end

		// back to back writes, valid stays high until the last one
		for (int i = 0; i < 10; i++) begin
			data = 8'($random(seed));
			write_port(data, i != 9);
		end
		wait_frames_done();
		next_cycle(6);

		// foreign addresses are never decoded
		for (int i = 0; i < 5; i++) begin
			addr = 8'($random(seed));
			if (addr == c_io_port) begin
				addr = addr ^ 8'h01;
			end
			bus_req.address = addr;
			bus_req.ioreq = 1'b1;
			bus_req.write = (i % 2 == 0);
			bus_req.valid = 1'b1;
			bus_req.wdata = 8'($random(seed));
			for (int k = 0; k < c_decode_cycles; k++) begin
				@(negedge clk);
				check(32'(bus_rsp.ready), 32'd0, "ready on a foreign address");
				check(32'(uart_tx), 32'd1, "line idle on a foreign address");
				check(32'(bus_rsp.rdata_en), 32'd0, "rdata_en on a foreign address");
			end
			next_cycle(1);
			bus_req = '0;
		end

		// button reads, each value held well past the filter delay
		for (int i = 0; i < 20; i++) begin
			model_buttons = c_button_width'($random(seed));
			button = model_buttons;
			next_cycle(12);
			read_port(8'(model_buttons));
		end

		// a 2 cycle glitch on every button must not get through
		model_buttons = 5'b01010;
		button = model_buttons;
		next_cycle(12);
		read_port(8'(model_buttons));
		button = ~model_buttons;
		next_cycle(2);
		button = model_buttons;
		// this read is accepted while the glitch still sits in the synchronizer
		// and an unfiltered path would return the inverted value here
		read_port(8'(model_buttons));
		next_cycle(12);
		read_port(8'(model_buttons));

		wait_frames_done();
		next_cycle(10);
		check(32'(decode_count), 32'(write_count), "decoded frame count");
		check(32'(expected_bytes.size()), 32'd0, "bytes left in the expected queue");
		$display("all tests passed");
		$finish;
	end

endmodule

/* tb/uart_io_asserts.sv */
// handshake and serial line checks for the uart port
// bound into the port, watches the read response pulse, ready against
// the transmitter busy flag and the idle line level

`timescale 1ns/1ps

module uart_io_asserts (
	input logic                  clk,
	input logic                  reset_n,
	input uart_io_pkg::bus_rsp_t bus_rsp,
	input logic                  send_busy,
	input logic                  uart_tx
);

	// ------------------------------------------------------------------
	// bus rules
	// ------------------------------------------------------------------
	// the read response lasts exactly one cycle
	a_rdata_en_single: assert property (@(posedge clk) disable iff (!reset_n)
		bus_rsp.rdata_en |=> !bus_rsp.rdata_en)
		else $error("rdata_en high for two cycles in a row");

	// no new transfer can be offered while a frame is going out
	a_ready_not_busy: assert property (@(posedge clk) disable iff (!reset_n)
		!(bus_rsp.ready && send_busy))
		else $error("ready high while the transmitter is busy");

	// ------------------------------------------------------------------
	// line rule
	// ------------------------------------------------------------------
	a_idle_line_high: assert property (@(posedge clk) disable iff (!reset_n)
		!send_busy |-> uart_tx)
		else $error("uart line low while the transmitter is idle");

endmodule

bind uart_io_port uart_io_asserts i_uart_io_asserts (
	.clk       (clk),
	.reset_n   (reset_n),
	.bus_rsp   (bus_rsp),
	.send_busy (send_busy),
	.uart_tx   (uart_tx)
);

/* verilog/uart_io_top.sv */
// uart io top level
// button conditioner feeding the memory mapped port, which in turn owns
// the serial transmitter driving the uart line

`timescale 1ns/1ps

module uart_io_top (
	input  logic                                   clk,
	input  logic                                   reset_n,
	input  uart_io_pkg::bus_req_t                  bus_req,
	output uart_io_pkg::bus_rsp_t                  bus_rsp,
	input  logic [uart_io_pkg::c_button_width-1:0] button,
	output logic                                   uart_tx
);
	import uart_io_pkg::*;

	// debounced button levels, read through the port
	logic [c_button_width-1:0] buttons_stable;

	// ------------------------------------------------------------------
	// button conditioning
	// ------------------------------------------------------------------
	button_sync i_button_sync (
		.clk            (clk),
		.reset_n        (reset_n),
		.button         (button),
		.buttons_stable (buttons_stable)
	);

	// ------------------------------------------------------------------
	// bus port with serial transmitter
	// ------------------------------------------------------------------
	uart_io_port i_uart_io_port (
		.clk            (clk),
		.reset_n        (reset_n),
		.bus_req        (bus_req),
		.bus_rsp        (bus_rsp),
		.buttons_stable (buttons_stable),
		.uart_tx        (uart_tx)
	);

endmodule

/* verilog/uart_io_port.sv */
// memory mapped uart port
// decodes one io address on the bus, a write sends the byte out through
// the serial transmitter and a read returns the debounced buttons,
// zero extended, in the cycle after the read is accepted

`timescale 1ns/1ps

module uart_io_port (
	input  logic                                   clk,
	input  logic                                   reset_n,
	input  uart_io_pkg::bus_req_t                  bus_req,
	output uart_io_pkg::bus_rsp_t                  bus_rsp,
	input  logic [uart_io_pkg::c_button_width-1:0] buttons_stable,
	output logic                                   uart_tx
);
	import uart_io_pkg::*;

	logic       port_dec;
	logic       port_ready;
	logic       accept;
	logic [7:0] wr_byte;
	logic       send_req;
	logic       send_busy;
	logic [7:0] rd_byte;
	logic       rd_en;

	// ------------------------------------------------------------------
	// decode and handshake
	// ------------------------------------------------------------------
	assign port_dec = (bus_req.address == c_io_port) && bus_req.ioreq;

	// one transfer at a time, so ready waits out a pending send request,
	// the whole serial frame and the read response cycle
	assign port_ready = port_dec && !send_req && !send_busy && !rd_en;
	assign accept = port_ready && bus_req.valid;

	assign bus_rsp.ready = port_ready;
	assign bus_rsp.rdata = rd_en ? rd_byte : 8'd0;
	assign bus_rsp.rdata_en = rd_en;

	// ------------------------------------------------------------------
	// control flags
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			send_req <= 1'b0;
			rd_en    <= 1'b0;
		end else begin
			// read response is a single cycle pulse after acceptance
			rd_en <= accept && !bus_req.write;
			if (send_req && send_busy) begin
				// transmitter has the byte, drop the request
				send_req <= 1'b0;
			end else if (accept && bus_req.write) begin
				send_req <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// data registers
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (accept && bus_req.write) begin
			wr_byte <= bus_req.wdata;
		end
		if (accept && !bus_req.write) begin
			// upper bits above the buttons read as zero
			rd_byte <= {{(8 - c_button_width){1'b0}}, buttons_stable};
		end
	end

	// serial transmitter, only takes a byte while idle
	uart_tx i_uart_tx (
		.clk       (clk),
		.reset_n   (reset_n),
		.send_data (wr_byte),
		.send_req  (send_req),
		.send_busy (send_busy),
		.tx        (uart_tx)
	);

endmodule

/* verilog/button_sync.sv */
// push button conditioner
// each button passes a two-flop synchronizer and then a debounce counter
// that needs c_debounce_clocks equal samples before the output follows

`timescale 1ns/1ps

module button_sync (
	input  logic                                   clk,
	input  logic                                   reset_n,
	input  logic [uart_io_pkg::c_button_width-1:0] button,
	output logic [uart_io_pkg::c_button_width-1:0] buttons_stable
);
	import uart_io_pkg::*;

	logic [c_button_width-1:0]       sync_1;
	logic [c_button_width-1:0]       sync_2;
	logic [c_debounce_cnt_width-1:0] stable_cnt [c_button_width];

	// ------------------------------------------------------------------
	// synchronizer
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			sync_1 <= '0;
			sync_2 <= '0;
		end else begin
			sync_1 <= button;
			sync_2 <= sync_1;
		end
	end

	// ------------------------------------------------------------------
	// debounce filter
	// ------------------------------------------------------------------
	// a counter per button tracks how long the synchronized input has
	// differed from the accepted value, any agreeing sample clears it
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			buttons_stable <= '0;
			for (int i = 0; i < c_button_width; i++) begin
				stable_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < c_button_width; i++) begin
				if (sync_2[i] == buttons_stable[i]) begin
					stable_cnt[i] <= '0;
				end else if (stable_cnt[i] ==
						c_debounce_cnt_width'(c_debounce_clocks - 1)) begin
					// the new level has now held for c_debounce_clocks samples
					stable_cnt[i]     <= '0;
					buttons_stable[i] <= sync_2[i];
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

/* verilog/uart_tx.sv */
// serial transmitter, 8N1
// takes one byte when idle and a send request is seen, then shifts out
// a start bit, eight data bits lsb first and a stop bit, each bit held
// for c_bit_clocks cycles

`timescale 1ns/1ps

module uart_tx (
	input  logic       clk,
	input  logic       reset_n,
	input  logic [7:0] send_data,
	input  logic       send_req,
	output logic       send_busy,
	output logic       tx
);
	import uart_io_pkg::*;

	tx_state_t                  state;
	logic [c_bit_cnt_width-1:0] bit_cnt;
	logic [2:0]                 bit_idx;
	logic [7:0]                 shift_reg;
	logic                       bit_end;

	// the counter runs 1 to c_bit_clocks inside a bit, the start bit begins
	// at 0 so the load cycle after the request is not counted as line time
	assign bit_end = (bit_cnt == c_bit_cnt_width'(c_bit_clocks));

	// busy covers the load cycle and every bit up to the end of the stop bit
	assign send_busy = (state != tx_idle);

	// ------------------------------------------------------------------
	// control FSM and line register
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state   <= tx_idle;
			bit_cnt <= '0;
			bit_idx <= '0;
			tx      <= 1'b1;
		end else begin
			case (state)
				tx_idle: begin
					// line rests high between frames
					tx      <= 1'b1;
					bit_cnt <= '0;
					bit_idx <= '0;
					if (send_req) begin
						state <= tx_start;
					end
				end
				tx_start: begin
					if (bit_end) begin
						// first data bit goes out on the same edge
						state   <= tx_data;
						bit_cnt <= c_bit_cnt_width'(1);
						tx      <= shift_reg[0];
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
						tx      <= 1'b0;
					end
				end
				tx_data: begin
					if (bit_end) begin
						bit_cnt <= c_bit_cnt_width'(1);
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= tx_stop;
							tx    <= 1'b1;
						end else begin
							// shift_reg moves on this edge, so bit 1 is the next one
							tx <= shift_reg[1];
						end
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				tx_stop: begin
					if (bit_end) begin
						state   <= tx_idle;
						bit_cnt <= '0;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: begin
					state <= tx_idle;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------
	// data shift register
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (state == tx_idle && send_req) begin
			shift_reg <= send_data;
		end else if (state == tx_data && bit_end) begin
			// lsb first, so shift right after each data bit
			shift_reg <= {1'b0, shift_reg[7:1]};
		end
	end

endmodule

/* verilog/uart_io_pkg.sv */
// uart io port shared definitions
// bus request and response structs, transmitter states and the timing
// constants used by the serial transmitter and the button filter

package uart_io_pkg;

	// ------------------------------------------------------------------
	// bus structs
	// ------------------------------------------------------------------

	// request from the bus master, held stable while valid is high
	typedef struct packed {
		logic [7:0] address;
		logic       ioreq;
		logic       write;
		logic       valid;
		logic [7:0] wdata;
	} bus_req_t;

	// response back to the master, rdata is zero outside the rdata_en cycle
	typedef struct packed {
		logic       ready;
		logic [7:0] rdata;
		logic       rdata_en;
	} bus_rsp_t;

	// serial frame phases of the transmitter FSM
	typedef enum logic [1:0] {
		tx_idle  = 2'd0,
		tx_start = 2'd1,
		tx_data  = 2'd2,
		tx_stop  = 2'd3
	} tx_state_t;

	// ------------------------------------------------------------------
	// constants
	// ------------------------------------------------------------------
	localparam logic [7:0] c_io_port = 8'h10;
	localparam int c_clk_freq = 10_000_000;
	localparam int c_uart_freq = 1_250_000;
	// clocks spent on each serial bit
	localparam int c_bit_clocks = c_clk_freq / c_uart_freq;
	// the bit counter runs up to c_bit_clocks itself, hence the extra value
	localparam int c_bit_cnt_width = $clog2(c_bit_clocks + 1);
	localparam int c_button_width = 5;
	localparam int c_debounce_clocks = 4;
	localparam int c_debounce_cnt_width = $clog2(c_debounce_clocks + 1);

endpackage
